//--- design/wh_dma_pkg.sv
// wormhole to DMA bridge shared definitions
// flit and DMA field types plus the header flit layout
package wh_dma_pkg;

  localparam int flit_width_c = 32;

  // one link flit, also one DMA data word
  typedef logic [flit_width_c-1:0] flit_t;

  // DMA byte address, low bits of the address flit
  typedef logic [27:0] addr_t;

  // network coordinate and requester channel id
  typedef logic [7:0] cord_t;
  typedef logic [3:0] cid_t;

  // flits following a header
  typedef logic [3:0] len_t;

  // header flit layout, bits 31:29 are unused
  localparam int hdr_cord_lsb_c = 0;
  localparam int hdr_cord_msb_c = 7;

  localparam int hdr_len_lsb_c = 8;
  localparam int hdr_len_msb_c = 11;

  localparam int hdr_cid_lsb_c = 12;
  localparam int hdr_cid_msb_c = 15;

  // where the response has to go back to
  localparam int hdr_src_cord_lsb_c = 16;
  localparam int hdr_src_cord_msb_c = 23;

  localparam int hdr_src_cid_lsb_c = 24;
  localparam int hdr_src_cid_msb_c = 27;

  // set for a write packet, clear for a read
  localparam int hdr_wnr_bit_c = 28;

endpackage

//--- design/dma_if.sv
// cache DMA bundle between the converter and the burst memory
// command, write data and read data channels
`timescale 1ns/1ps

interface dma_if;

  // command, yumi from the memory
  logic                 pkt_v;
  logic                 pkt_write;
  wh_dma_pkg::addr_t    pkt_addr;
  logic                 pkt_yumi;

  // write data toward the memory
  wh_dma_pkg::flit_t    wdata;
  logic                 wdata_v;
  logic                 wdata_yumi;

  // read data back, ready and valid
  wh_dma_pkg::flit_t    rdata;
  logic                 rdata_v;
  logic                 rdata_ready;

  modport conv (
    output pkt_v, pkt_write, pkt_addr,
    input  pkt_yumi,
    output wdata, wdata_v,
    input  wdata_yumi,
    input  rdata, rdata_v,
    output rdata_ready
  );

  modport mem (
    input  pkt_v, pkt_write, pkt_addr,
    output pkt_yumi,
    input  wdata, wdata_v,
    output wdata_yumi,
    output rdata, rdata_v,
    input  rdata_ready
  );

endinterface

//--- design/wh_flit_fifo.sv
// input flit buffer for the request link
// ready and valid on the input, valid then yumi on the output
`timescale 1ns/1ps

module wh_flit_fifo #(
  parameter int fifo_depth_p = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,

  input  wh_dma_pkg::flit_t flit_i,
  input  logic              v_i,
  output logic              ready_o,

  output wh_dma_pkg::flit_t flit_o,
  output logic              v_o,
  input  logic              yumi_i
);

  localparam int ptr_w_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_w_lp = $clog2(fifo_depth_p + 1);

  wh_dma_pkg::flit_t     buf_r [fifo_depth_p];
  logic [ptr_w_lp-1:0]   wptr_r;
  logic [ptr_w_lp-1:0]   rptr_r;
  logic [cnt_w_lp-1:0]   count_r;
  logic                  push;

  assign ready_o = (count_r != cnt_w_lp'(fifo_depth_p));
  assign v_o     = (count_r != '0);
  assign flit_o  = buf_r[rptr_r];
  assign push    = v_i & ready_o;

  // flit storage written on each push
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_r[wptr_r] <= flit_i;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= (wptr_r == ptr_w_lp'(fifo_depth_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (yumi_i) begin
        rptr_r <= (rptr_r == ptr_w_lp'(fifo_depth_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(push) - cnt_w_lp'(yumi_i);
    end
  end

  // the converter may only pop a flit that is there
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o
  );

endmodule

//--- design/wh_to_dma_stream.sv
// wormhole packet to cache DMA converter
// send side turns request packets into DMA commands and write data,
// receive side wraps read bursts into response packets
`timescale 1ns/1ps

module wh_to_dma_stream #(
  parameter int burst_len_p = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,

  input  wh_dma_pkg::flit_t flit_i,
  input  logic              flit_v_i,
  output logic              flit_yumi_o,

  dma_if.conv               dma,

  output wh_dma_pkg::flit_t rsp_flit_o,
  output logic              rsp_v_o,
  input  logic              rsp_ready_i
);

  localparam int cnt_w_lp = (burst_len_p > 1) ? $clog2(burst_len_p) : 1;
  localparam logic [cnt_w_lp-1:0] last_beat_lp = cnt_w_lp'(burst_len_p - 1);

  typedef enum logic [1:0] {
    SEND_RESET,
    SEND_READY,
    SEND_CMD,
    SEND_WDATA
  } send_state_e;

  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_HEADER,
    RECV_FILL
  } recv_state_e;

  send_state_e           send_state_r, send_state_n;
  recv_state_e           recv_state_r, recv_state_n;
  logic                  wnr_r;
  logic                  read_pend_r;
  logic                  hdr_take;
  logic                  rd_issue;
  logic                  rd_done;
  logic [cnt_w_lp-1:0]   send_cnt_r;
  logic [cnt_w_lp-1:0]   recv_cnt_r;
  logic                  wbeat;
  logic                  rbeat;

  // single entry source table, the requester of the open read
  wh_dma_pkg::cord_t     src_cord_r;
  wh_dma_pkg::cid_t      src_cid_r;
  wh_dma_pkg::flit_t     rsp_hdr;

  // a new header waits while a read response is still owed, so the
  // table entry stays put until its header has gone out
  assign hdr_take = (send_state_r == SEND_READY) & flit_v_i & ~read_pend_r;
  assign rd_issue = (send_state_r == SEND_CMD) & dma.pkt_yumi & ~wnr_r;
  assign wbeat    = (send_state_r == SEND_WDATA) & dma.wdata_yumi;
  assign rbeat    = (recv_state_r == RECV_FILL) & dma.rdata_v & rsp_ready_i;
  assign rd_done  = rbeat & (recv_cnt_r == last_beat_lp);

  assign dma.pkt_write = wnr_r;
  assign dma.pkt_addr  = flit_i[$bits(wh_dma_pkg::addr_t)-1:0];
  assign dma.wdata     = flit_i;

  always_comb begin
    send_state_n = send_state_r;
    flit_yumi_o  = 1'b0;
    dma.pkt_v    = 1'b0;
    dma.wdata_v  = 1'b0;
    case (send_state_r)
      SEND_RESET: send_state_n = SEND_READY;
      SEND_READY: begin
        flit_yumi_o = hdr_take;
        if (hdr_take) begin
          send_state_n = SEND_CMD;
        end
      end
      // address flit leaves with the command
      SEND_CMD: begin
        dma.pkt_v   = flit_v_i;
        flit_yumi_o = dma.pkt_yumi;
        if (dma.pkt_yumi) begin
          send_state_n = wnr_r ? SEND_WDATA : SEND_READY;
        end
      end
      SEND_WDATA: begin
        dma.wdata_v = flit_v_i;
        flit_yumi_o = dma.wdata_yumi;
        if (wbeat && send_cnt_r == last_beat_lp) begin
          send_state_n = SEND_READY;
        end
      end
      default: send_state_n = SEND_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (hdr_take) begin
      src_cord_r <= flit_i[wh_dma_pkg::hdr_src_cord_msb_c:wh_dma_pkg::hdr_src_cord_lsb_c];
      src_cid_r  <= flit_i[wh_dma_pkg::hdr_src_cid_msb_c:wh_dma_pkg::hdr_src_cid_lsb_c];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_RESET;
      wnr_r        <= 1'b0;
      send_cnt_r   <= '0;
      read_pend_r  <= 1'b0;
    end else begin
      send_state_r <= send_state_n;
      if (hdr_take) begin
        wnr_r <= flit_i[wh_dma_pkg::hdr_wnr_bit_c];
      end
      if (wbeat) begin
        send_cnt_r <= (send_cnt_r == last_beat_lp) ? '0 : send_cnt_r + 1'b1;
      end
      if (rd_issue) begin
        read_pend_r <= 1'b1;
      end else if (rd_done) begin
        read_pend_r <= 1'b0;
      end
    end
  end

  // response header back to the requester
  always_comb begin
    rsp_hdr = '0;
    rsp_hdr[wh_dma_pkg::hdr_cord_msb_c:wh_dma_pkg::hdr_cord_lsb_c] = src_cord_r;
    rsp_hdr[wh_dma_pkg::hdr_cid_msb_c:wh_dma_pkg::hdr_cid_lsb_c]   = src_cid_r;
    rsp_hdr[wh_dma_pkg::hdr_len_msb_c:wh_dma_pkg::hdr_len_lsb_c] =
      wh_dma_pkg::len_t'(burst_len_p);
  end

  always_comb begin
    recv_state_n    = recv_state_r;
    rsp_v_o         = 1'b0;
    rsp_flit_o      = rsp_hdr;
    dma.rdata_ready = 1'b0;
    case (recv_state_r)
      RECV_RESET: recv_state_n = RECV_HEADER;
      // header goes out once the burst has started
      RECV_HEADER: begin
        rsp_v_o = dma.rdata_v;
        if (dma.rdata_v && rsp_ready_i) begin
          recv_state_n = RECV_FILL;
        end
      end
      RECV_FILL: begin
        rsp_v_o         = dma.rdata_v;
        rsp_flit_o      = dma.rdata;
        dma.rdata_ready = rsp_ready_i;
        if (rd_done) begin
          recv_state_n = RECV_HEADER;
        end
      end
      default: recv_state_n = RECV_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      recv_state_r <= RECV_RESET;
      recv_cnt_r   <= '0;
    end else begin
      recv_state_r <= recv_state_n;
      if (rbeat) begin
        recv_cnt_r <= (recv_cnt_r == last_beat_lp) ? '0 : recv_cnt_r + 1'b1;
      end
    end
  end

  // len field has to be wide enough for the burst
  a_hdr_len_fits: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (rsp_v_o && recv_state_r == RECV_HEADER) |->
      (rsp_flit_o[wh_dma_pkg::hdr_len_msb_c:wh_dma_pkg::hdr_len_lsb_c] >= burst_len_p)
  );

endmodule

//--- design/dma_burst_mem.sv
// burst memory behind the DMA port
// serves one read or write burst at a time from a word array
`timescale 1ns/1ps

module dma_burst_mem #(
  parameter int burst_len_p = 4,
  parameter int mem_words_p = 64
) (
  input  logic clk_i,
  input  logic reset_i,
  dma_if.mem   dma
);

  localparam int idx_w_lp = $clog2(mem_words_p);
  localparam int beat_w_lp = (burst_len_p > 1) ? $clog2(burst_len_p) : 1;
  localparam logic [beat_w_lp-1:0] last_beat_lp = beat_w_lp'(burst_len_p - 1);

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WRITE,
    MEM_READ
  } mem_state_e;

  mem_state_e             state_r;
  wh_dma_pkg::flit_t      mem_r [mem_words_p];
  logic [idx_w_lp-1:0]    cmd_idx;
  logic [idx_w_lp-1:0]    base_r;
  logic [idx_w_lp-1:0]    word_idx;
  logic [beat_w_lp-1:0]   beat_r;
  logic                   beat_last;

  // byte address to word index, aligned down to the burst
  assign cmd_idx = dma.pkt_addr[idx_w_lp+1:2] & ~idx_w_lp'(burst_len_p - 1);
  assign word_idx = base_r + idx_w_lp'(beat_r);
  assign beat_last = (beat_r == last_beat_lp);

  assign dma.pkt_yumi   = (state_r == MEM_IDLE) & dma.pkt_v;
  assign dma.wdata_yumi = (state_r == MEM_WRITE) & dma.wdata_v;
  assign dma.rdata_v    = (state_r == MEM_READ);
  assign dma.rdata      = mem_r[word_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= MEM_IDLE;
      base_r  <= '0;
      beat_r  <= '0;
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else begin
      case (state_r)
        MEM_IDLE: begin
          if (dma.pkt_yumi) begin
            base_r  <= cmd_idx;
            beat_r  <= '0;
            state_r <= dma.pkt_write ? MEM_WRITE : MEM_READ;
          end
        end
        MEM_WRITE: begin
          if (dma.wdata_yumi) begin
            mem_r[word_idx] <= dma.wdata;
            beat_r <= beat_r + 1'b1;
            if (beat_last) begin
              state_r <= MEM_IDLE;
            end
          end
        end
        // word holds until the converter takes it
        MEM_READ: begin
          if (dma.rdata_ready) begin
            beat_r <= beat_r + 1'b1;
            if (beat_last) begin
              state_r <= MEM_IDLE;
            end
          end
        end
        default: state_r <= MEM_IDLE;
      endcase
    end
  end

  // write beats from the converter only ever arrive during a write burst
  a_wdata_only_in_write: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dma.wdata_v |-> (state_r == MEM_WRITE)
  );

endmodule

//--- design/wh_dma_top.sv
// wormhole link to cache DMA bridge, top level
// input flit buffer, packet converter and burst memory
`timescale 1ns/1ps

module wh_dma_top #(
  parameter int burst_len_p  = 4,
  parameter int fifo_depth_p = 4,
  parameter int mem_words_p  = 64
) (
  input  logic              clk_i,
  input  logic              reset_i,

  // request link in
  input  wh_dma_pkg::flit_t req_flit_i,
  input  logic              req_v_i,
  output logic              req_ready_o,

  // response link out
  output wh_dma_pkg::flit_t rsp_flit_o,
  output logic              rsp_v_o,
  input  logic              rsp_ready_i
);

  wh_dma_pkg::flit_t buf_flit;
  logic              buf_v;
  logic              buf_yumi;

  dma_if dma_bus ();

  wh_flit_fifo #(
    .fifo_depth_p(fifo_depth_p)
  ) wh_flit_fifo_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .flit_i (req_flit_i),
    .v_i    (req_v_i),
    .ready_o(req_ready_o),
    .flit_o (buf_flit),
    .v_o    (buf_v),
    .yumi_i (buf_yumi)
  );

  wh_to_dma_stream #(
    .burst_len_p(burst_len_p)
  ) wh_to_dma_stream_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flit_i     (buf_flit),
    .flit_v_i   (buf_v),
    .flit_yumi_o(buf_yumi),
    .dma        (dma_bus.conv),
    .rsp_flit_o (rsp_flit_o),
    .rsp_v_o    (rsp_v_o),
    .rsp_ready_i(rsp_ready_i)
  );

  dma_burst_mem #(
    .burst_len_p(burst_len_p),
    .mem_words_p(mem_words_p)
  ) dma_burst_mem_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .dma    (dma_bus.mem)
  );

endmodule

//--- verif/wh_dma_tb_clock.sv
// testbench clock source
// free running clock, 100 ns period with the default half period
`timescale 1ns/1ps

module wh_dma_tb_clock #(
  parameter int half_period_p = 50
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(half_period_p) clk_o = ~clk_o;
  end

endmodule

//--- verif/wh_dma_tb.sv
// testbench for the wormhole to DMA bridge
// random read and write packets from an LFSR, a shadow memory as the model,
// response packets checked flit by flit under random back-pressure
`timescale 1ns/1ps

module wh_dma_tb;

  localparam int burst_len_p   = 4;
  localparam int fifo_depth_p  = 4;
  localparam int mem_words_p   = 64;
  localparam int num_bursts_lp = mem_words_p / burst_len_p;
  localparam int num_ops_lp    = 80;
  localparam int wait_limit_lp = 1000;

  logic              clk_i;
  logic              reset_i;
  wh_dma_pkg::flit_t req_flit_i;
  logic              req_v_i;
  logic              req_ready_o;
  wh_dma_pkg::flit_t rsp_flit_o;
  logic              rsp_v_o;
  logic              rsp_ready_i;

  wh_dma_pkg::flit_t shadow_mem [mem_words_p];
  // expected response flits, a header and then the burst words
  wh_dma_pkg::flit_t exp_q [$];
  logic [31:0]       drv_lfsr;
  logic [31:0]       rsp_lfsr;
  logic              send_done;
  int                reads_sent;
  int                responses_seen;

  wh_dma_tb_clock #(.half_period_p(50)) clock_gen (.clk_o(clk_i));

  wh_dma_top #(
    .burst_len_p (burst_len_p),
    .fifo_depth_p(fifo_depth_p),
    .mem_words_p (mem_words_p)
  ) wh_dma_top_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_flit_i (req_flit_i),
    .req_v_i    (req_v_i),
    .req_ready_o(req_ready_o),
    .rsp_flit_o (rsp_flit_o),
    .rsp_v_o    (rsp_v_o),
    .rsp_ready_i(rsp_ready_i)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  function automatic logic [31:0] header_field(input wh_dma_pkg::flit_t f, input int msb,
                                               input int lsb);
    return (f >> lsb) & ((32'h1 << (msb - lsb + 1)) - 32'h1);
  endfunction

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t waiting for %s", $time, what);
    stop_run();
  endtask

  function automatic wh_dma_pkg::flit_t req_header(input logic wnr,
                                                   input wh_dma_pkg::cord_t src_cord,
                                                   input wh_dma_pkg::cid_t src_cid,
                                                   input wh_dma_pkg::len_t len);
    wh_dma_pkg::flit_t h;
    h = '0;
    h[wh_dma_pkg::hdr_len_msb_c:wh_dma_pkg::hdr_len_lsb_c] = len;
    h[wh_dma_pkg::hdr_src_cord_msb_c:wh_dma_pkg::hdr_src_cord_lsb_c] = src_cord;
    h[wh_dma_pkg::hdr_src_cid_msb_c:wh_dma_pkg::hdr_src_cid_lsb_c] = src_cid;
    h[wh_dma_pkg::hdr_wnr_bit_c] = wnr;
    return h;
  endfunction

  // holds the flit until the buffer takes it, leaves 1 ns after that edge
  task automatic send_flit(input wh_dma_pkg::flit_t flit);
    int waited;
    waited = 0;
    req_flit_i = flit;
    req_v_i = 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) begin
      waited++;
      if (waited > wait_limit_lp) begin
        report_timeout("req_ready_o on the request link");
      end
      @(posedge clk_i);
    end
    #1;
    req_v_i = 1'b0;
  endtask

  task automatic idle_gap();
    logic [31:0] g;
    logic [31:0] n;
    take_bits(drv_lfsr, 2, g);
    if (g == 0) begin
      take_bits(drv_lfsr, 2, n);
      repeat (n + 1) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_packet(input logic wnr, input int burst,
                             input wh_dma_pkg::cord_t src_cord, input wh_dma_pkg::cid_t src_cid);
    wh_dma_pkg::flit_t hdr;
    logic [31:0]       data;
    int                base;
    wh_dma_pkg::len_t  len;
    base = burst * burst_len_p;
    len = wnr ? wh_dma_pkg::len_t'(burst_len_p + 1) : wh_dma_pkg::len_t'(1);
    if (!wnr) begin
      // the response goes back to the requester, data as the model has it now
      hdr = '0;
      hdr[wh_dma_pkg::hdr_cord_msb_c:wh_dma_pkg::hdr_cord_lsb_c] = src_cord;
      hdr[wh_dma_pkg::hdr_cid_msb_c:wh_dma_pkg::hdr_cid_lsb_c] = src_cid;
      hdr[wh_dma_pkg::hdr_len_msb_c:wh_dma_pkg::hdr_len_lsb_c] = wh_dma_pkg::len_t'(burst_len_p);
      exp_q.push_back(hdr);
      for (int i = 0; i < burst_len_p; i++) begin
        exp_q.push_back(shadow_mem[base + i]);
      end
      reads_sent++;
    end
    idle_gap();
    send_flit(req_header(wnr, src_cord, src_cid, len));
    idle_gap();
    send_flit(wh_dma_pkg::flit_t'(base * 4));
    if (wnr) begin
      for (int i = 0; i < burst_len_p; i++) begin
        take_bits(drv_lfsr, 32, data);
        shadow_mem[base + i] = data;
        idle_gap();
        send_flit(data);
      end
    end
  endtask

  task automatic run_operations();
    logic [31:0] r_op;
    logic [31:0] r_burst;
    logic [31:0] r_cord;
    logic [31:0] r_cid;
    // write then read back one burst, then a burst nothing has written
    send_packet(1'b1, 2, 8'h15, 4'h3);
    send_packet(1'b0, 2, 8'h2a, 4'h9);
    send_packet(1'b0, num_bursts_lp - 1, 8'h07, 4'h1);
    for (int i = 0; i < num_ops_lp; i++) begin
      take_bits(drv_lfsr, 1, r_op);
      take_bits(drv_lfsr, 8, r_burst);
      take_bits(drv_lfsr, 8, r_cord);
      take_bits(drv_lfsr, 4, r_cid);
      send_packet(r_op[0], int'(r_burst % num_bursts_lp), wh_dma_pkg::cord_t'(r_cord),
                  wh_dma_pkg::cid_t'(r_cid));
    end
    send_done = 1'b1;
  endtask

  // beat 0 is the header, beats 1 to burst_len_p are data
  task automatic collect_responses();
    wh_dma_pkg::flit_t exp;
    logic [31:0]       r;
    int                idle;
    int                beat;
    idle = 0;
    beat = 0;
    while (!send_done || exp_q.size() != 0) begin
      take_bits(rsp_lfsr, 2, r);
      rsp_ready_i = (r != 0);
      @(posedge clk_i);
      if (rsp_v_o && rsp_ready_i) begin
        idle = 0;
        if (exp_q.size() == 0) begin
          $display("a response flit arrived at %0t with no read outstanding", $time);
          stop_run();
        end
        exp = exp_q.pop_front();
        if (beat == 0) begin
          check_value(header_field(exp, wh_dma_pkg::hdr_cord_msb_c, wh_dma_pkg::hdr_cord_lsb_c),
                      header_field(rsp_flit_o, wh_dma_pkg::hdr_cord_msb_c,
                                   wh_dma_pkg::hdr_cord_lsb_c),
                      "response header cord");
          check_value(header_field(exp, wh_dma_pkg::hdr_cid_msb_c, wh_dma_pkg::hdr_cid_lsb_c),
                      header_field(rsp_flit_o, wh_dma_pkg::hdr_cid_msb_c,
                                   wh_dma_pkg::hdr_cid_lsb_c),
                      "response header cid");
          check_value(32'(burst_len_p),
                      header_field(rsp_flit_o, wh_dma_pkg::hdr_len_msb_c,
                                   wh_dma_pkg::hdr_len_lsb_c),
                      "response header len");
        end else begin
          check_value(exp, rsp_flit_o, "read data word");
        end
        if (beat == burst_len_p) begin
          beat = 0;
          responses_seen++;
        end else begin
          beat++;
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > wait_limit_lp) begin
          report_timeout("a response flit");
        end
      end
      #1;
    end
    rsp_ready_i = 1'b1;
  endtask

  initial begin
    int waited;
    reset_i        = 1'b1;
    req_flit_i     = '0;
    req_v_i        = 1'b0;
    rsp_ready_i    = 1'b0;
    drv_lfsr       = 32'h7102;
    rsp_lfsr       = 32'h7102;
    send_done      = 1'b0;
    reads_sent     = 0;
    responses_seen = 0;
    waited         = 0;
    for (int i = 0; i < mem_words_p; i++) begin
      shadow_mem[i] = '0;
    end

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(posedge clk_i);
    check_value(32'd0, 32'(rsp_v_o), "rsp_v_o after reset");
    while (!req_ready_o) begin
      waited++;
      if (waited > 20) begin
        report_timeout("req_ready_o after reset");
      end
      @(posedge clk_i);
    end
    #1;

    fork
      run_operations();
      collect_responses();
    join

    check_value(32'(reads_sent), 32'(responses_seen), "number of read responses");
    // nothing extra may follow the last response
    repeat (20) begin
      @(posedge clk_i);
      check_value(32'd0, 32'(rsp_v_o), "rsp_v_o after the last response");
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- all.f
design/wh_dma_pkg.sv
design/dma_if.sv
design/wh_flit_fifo.sv
design/wh_to_dma_stream.sv
design/dma_burst_mem.sv
design/wh_dma_top.sv
verif/wh_dma_tb_clock.sv
verif/wh_dma_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the bridge and its testbench with Verilator, run, then search the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module wh_dma_tb \
  -o wh_dma_sim > build.log 2>&1 &&
./obj_dir/wh_dma_sim > sim.log 2>&1

grep -q "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
